/* heap_level_ram.sv */
`timescale 1ns/1ps

module heap_level_ram #(
	parameter int DEPTH = 1,
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
	input  logic            clk,
	input  logic [AW-1:0]   rd_addr,
	input  logic [AW-1:0]   wr_addr,
	input  logic            wr_en,
	input  heap_pkg::data_t wr_data,
	output heap_pkg::data_t rd_data
);

	heap_pkg::data_t mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Registered read; a read in the same cycle as a write to that
	// address returns the old word
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* heap_pkg.sv */
package heap_pkg;

	// Sample width
	localparam int DATA_W = 16;

	// Wide enough to index a node in any supported level
	localparam int POS_W = 16;

	typedef logic [DATA_W-1:0] data_t;

	typedef logic [POS_W-1:0] pos_t;

	// One sift wave moving down the heap.
	// pos is the node index inside the level that holds the token
	typedef struct packed {
		logic  valid;
		pos_t  pos;
		data_t data;
	} sift_token_t;

	// Clear sweep broadcast from the root to every level
	typedef struct packed {
		logic active;
		pos_t addr;
	} clear_t;

endpackage

/* heap_root.sv */
`timescale 1ns/1ps

module heap_root #(
	parameter int LEVELS = 6
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  fs,
	input  logic                  rec_en,
	input  heap_pkg::data_t       data_in,
	output heap_pkg::data_t       data_out,
	output logic                  out_valid,
	output logic                  ready,
	output heap_pkg::pos_t        child_addr,
	input  heap_pkg::data_t       child_l,
	input  heap_pkg::data_t       child_r,
	output heap_pkg::sift_token_t token,
	output heap_pkg::clear_t      clear
);

	// The sweep covers the widest level RAM
	localparam int CLR_LEN = 1 << (LEVELS - 2);

	logic            fs_s;
	logic            fs_d;
	logic            stb;
	logic            accept;
	logic            in_less;
	logic            ins_q;
	logic            go_right;
	logic            child_wins;
	heap_pkg::data_t root;
	heap_pkg::data_t sample_q;
	heap_pkg::data_t min_child;

	// One strobe per rising edge of the sample clock
	assign stb = fs_s & ~fs_d;
	assign accept = stb & ready;
	assign in_less = data_in < root;

	// The root is the only level 0 node, its children always live at address 0
	assign child_addr = '0;

	assign go_right = child_r < child_l;
	assign min_child = go_right ? child_r : child_l;
	assign child_wins = min_child < sample_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			fs_s <= 1'b0;
			fs_d <= 1'b0;
		end
		else
		begin
			fs_s <= fs;
			fs_d <= fs_s;
		end
	end

	// Clear sweep, one address per cycle, then ready for good
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			clear.active <= 1'b1;
			clear.addr <= '0;
			ready <= 1'b0;
		end
		else if (clear.active)
		begin
			if (clear.addr == heap_pkg::pos_t'(CLR_LEN - 1))
			begin
				clear.active <= 1'b0;
				ready <= 1'b1;
			end
			else
			begin
				clear.addr <= clear.addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			ins_q <= 1'b0;
		end
		else
		begin
			out_valid <= accept;
			// Samples below the root are dropped from the heap
			ins_q <= accept & rec_en & ~in_less;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			data_out <= in_less ? data_in : root;
			sample_q <= data_in;
		end
	end

	// Level 0 sift step, level 1 children were read while ins_q was set up
	always_ff @(posedge clk)
	begin
		if (clear.active)
			root <= '0;
		else if (ins_q)
			root <= child_wins ? min_child : sample_q;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			token.valid <= 1'b0;
		else
			token.valid <= ins_q & child_wins;
		// Level 1 position is just the side the smaller child came from
		token.pos <= heap_pkg::pos_t'(go_right);
		token.data <= sample_q;
	end

endmodule

/* sift_stage.sv */
`timescale 1ns/1ps

module sift_stage #(
	parameter int LEVELS = 6,
	parameter int LEVEL = 1
) (
	input  logic                  clk,
	input  logic                  rst,
	input  heap_pkg::sift_token_t token_in,
	output heap_pkg::sift_token_t token_out,
	input  heap_pkg::clear_t      clear,
	output heap_pkg::pos_t        wr_addr,
	output logic                  wr_en_l,
	output logic                  wr_en_r,
	output heap_pkg::data_t       wr_data,
	output heap_pkg::pos_t        child_addr,
	input  heap_pkg::data_t       child_l,
	input  heap_pkg::data_t       child_r
);

	// Entries in each of the two RAMs of this level
	localparam int SIZE = 1 << (LEVEL - 1);

	// The bottom level has no children to compare against
	localparam bit LAST = (LEVEL == LEVELS - 1);

	heap_pkg::sift_token_t tok_q;
	heap_pkg::data_t       min_child;
	logic                  go_right;
	logic                  child_wins;

	// Children of slot p are 2p and 2p+1, i.e. address p in both RAMs below
	assign child_addr = token_in.pos;

	// Hold the token while the child read completes
	always_ff @(posedge clk)
	begin
		if (rst)
			tok_q.valid <= 1'b0;
		else
			tok_q.valid <= token_in.valid;
		tok_q.pos <= token_in.pos;
		tok_q.data <= token_in.data;
	end

	assign go_right = child_r < child_l;
	assign min_child = go_right ? child_r : child_l;
	assign child_wins = !LAST && (min_child < tok_q.data);

	// Own slot write.
	// Even positions go to the left RAM, odd ones to the right RAM
	always_comb
	begin
		if (clear.active)
		begin
			wr_addr = clear.addr & heap_pkg::pos_t'(SIZE - 1);
			wr_en_l = 1'b1;
			wr_en_r = 1'b1;
			wr_data = '0;
		end
		else
		begin
			wr_addr = tok_q.pos >> 1;
			wr_en_l = tok_q.valid & ~tok_q.pos[0];
			wr_en_r = tok_q.valid & tok_q.pos[0];
			// Smaller child moves up, otherwise the wave settles here
			wr_data = child_wins ? min_child : tok_q.data;
		end
	end

	// Token continues towards the child that was moved up
	always_ff @(posedge clk)
	begin
		if (rst)
			token_out.valid <= 1'b0;
		else
			token_out.valid <= tok_q.valid & child_wins;
		token_out.pos <= {tok_q.pos[heap_pkg::POS_W-2:0], go_right};
		token_out.data <= tok_q.data;
	end

endmodule

/* streaming_heap.f */
heap_pkg.sv
heap_level_ram.sv
heap_root.sv
sift_stage.sv
streaming_heap.sv
tb_clock_gen.sv
streaming_heap_asserts.sv
streaming_heap_tb.sv

/* streaming_heap.sv */
`timescale 1ns/1ps

module streaming_heap #(
	parameter int LEVELS = 6
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            fs,
	input  logic            rec_en,
	input  heap_pkg::data_t data_in,
	output heap_pkg::data_t data_out,
	output logic            out_valid,
	output logic            ready
);

	// Token and read signals are indexed by the level that drives them
	heap_pkg::sift_token_t tok     [LEVELS];
	heap_pkg::pos_t        rd_addr [LEVELS];
	heap_pkg::data_t       rd_l    [LEVELS];
	heap_pkg::data_t       rd_r    [LEVELS];

	// Write ports, indexed by the level that owns the RAMs
	heap_pkg::pos_t        wr_addr [1:LEVELS-1];
	logic                  wr_en_l [1:LEVELS-1];
	logic                  wr_en_r [1:LEVELS-1];
	heap_pkg::data_t       wr_data [1:LEVELS-1];

	heap_pkg::clear_t      clear;

	heap_root #(
		.LEVELS(LEVELS)
	) u_root (
		.clk       (clk),
		.rst       (rst),
		.fs        (fs),
		.rec_en    (rec_en),
		.data_in   (data_in),
		.data_out  (data_out),
		.out_valid (out_valid),
		.ready     (ready),
		.child_addr(rd_addr[0]),
		.child_l   (rd_l[0]),
		.child_r   (rd_r[0]),
		.token     (tok[0]),
		.clear     (clear)
	);

	for (genvar k = 1; k < LEVELS; k++)
	begin : g_level
		localparam int DEPTH = 1 << (k - 1);
		localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

		// Left RAM holds even positions, right RAM the odd ones
		heap_level_ram #(.DEPTH(DEPTH)) u_ram_l (
			.clk    (clk),
			.rd_addr(rd_addr[k-1][AW-1:0]),
			.wr_addr(wr_addr[k][AW-1:0]),
			.wr_en  (wr_en_l[k]),
			.wr_data(wr_data[k]),
			.rd_data(rd_l[k-1])
		);

		heap_level_ram #(.DEPTH(DEPTH)) u_ram_r (
			.clk    (clk),
			.rd_addr(rd_addr[k-1][AW-1:0]),
			.wr_addr(wr_addr[k][AW-1:0]),
			.wr_en  (wr_en_r[k]),
			.wr_data(wr_data[k]),
			.rd_data(rd_r[k-1])
		);

		sift_stage #(
			.LEVELS(LEVELS),
			.LEVEL (k)
		) u_stage (
			.clk       (clk),
			.rst       (rst),
			.token_in  (tok[k-1]),
			.token_out (tok[k]),
			.clear     (clear),
			.wr_addr   (wr_addr[k]),
			.wr_en_l   (wr_en_l[k]),
			.wr_en_r   (wr_en_r[k]),
			.wr_data   (wr_data[k]),
			.child_addr(rd_addr[k]),
			.child_l   (rd_l[k]),
			.child_r   (rd_r[k])
		);

		// Bottom level has nothing below it
		if (k == LEVELS - 1)
		begin : g_leaf
			assign rd_l[k] = '0;
			assign rd_r[k] = '0;
		end
	end

endmodule

/* streaming_heap_asserts.sv */
`timescale 1ns/1ps

module streaming_heap_asserts #(
	parameter int LEVELS = 6
) (
	input logic clk,
	input logic rst,
	input logic fs,
	input logic ready,
	input logic out_valid
);

	// Length of the clear sweep after reset
	localparam int CLR_LEN = 1 << (LEVELS - 2);

	int fail_count = 0;

	// Outputs go quiet on every reset cycle
	a_reset_quiet: assert property (@(posedge clk) rst |=> !ready && !out_valid)
	else
	begin
		$error("ready or out_valid high right after a reset cycle");
		fail_count++;
	end

	// Clear sweep keeps ready low for exactly CLR_LEN cycles
	a_ready_rise: assert property (@(posedge clk) disable iff (rst)
		$fell(rst) |-> (!ready && !out_valid) [*CLR_LEN] ##1 ready)
	else
	begin
		$error("ready did not rise exactly at the end of the clear sweep");
		fail_count++;
	end

	a_ready_stays: assert property (@(posedge clk) disable iff (rst) ready |=> ready)
	else
	begin
		$error("ready dropped without a reset");
		fail_count++;
	end

	// Accepted edge gives a single cycle pulse two cycles after fs is seen high
	a_pulse_follows_edge: assert property (@(posedge clk) disable iff (rst)
		$rose(fs) ##1 ready |=> out_valid ##1 !out_valid)
	else
	begin
		$error("out_valid pulse missing or too long after an accepted fs edge");
		fail_count++;
	end

	a_pulse_has_cause: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> $past(fs, 2) && !$past(fs, 3) && $past(ready))
	else
	begin
		$error("out_valid pulse without an accepted fs edge");
		fail_count++;
	end

endmodule

bind streaming_heap streaming_heap_asserts #(
	.LEVELS(LEVELS)
) u_asserts (
	.clk      (clk),
	.rst      (rst),
	.fs       (fs),
	.ready    (ready),
	.out_valid(out_valid)
);

/* streaming_heap_tb.sv */
`timescale 1ns/1ps

module streaming_heap_tb;

	localparam int LEVELS = 6;
	localparam int HEAP_SIZE = (1 << LEVELS) - 1;
	localparam int CLR_LEN = 1 << (LEVELS - 2);
	localparam int FS_PERIOD = 4;
	// Includes the fs pulse that is sent during the second clear
	localparam int NUM_SAMPLES = 100 + 20 + 30 + 40 + 73 + 1;
	localparam int MAX_CYCLES = NUM_SAMPLES * FS_PERIOD + CLR_LEN + 200;
	localparam int READY_LIMIT = CLR_LEN + 40;

	logic            clk;
	logic            rst;
	logic            restart;
	logic            fs;
	logic            rec_en;
	heap_pkg::data_t data_in;
	heap_pkg::data_t data_out;
	logic            out_valid;
	logic            ready;

	// Reference heap contents as a plain multiset
	heap_pkg::data_t model [HEAP_SIZE];

	int mismatches;
	int missing;
	int samples_sent;
	int cycles;

	tb_clock_gen u_clk (
		.restart(restart),
		.clk    (clk),
		.rst    (rst)
	);

	streaming_heap #(
		.LEVELS(LEVELS)
	) u_streaming_heap (
		.clk      (clk),
		.rst      (rst),
		.fs       (fs),
		.rec_en   (rec_en),
		.data_in  (data_in),
		.data_out (data_out),
		.out_valid(out_valid),
		.ready    (ready)
	);

	task automatic clear_model();
		int i;
		for (i = 0; i < HEAP_SIZE; i++)
			model[i] = '0;
	endtask

	function automatic int lowest_slot();
		int i;
		int idx;
		idx = 0;
		for (i = 1; i < HEAP_SIZE; i++)
			if (model[i] < model[idx])
				idx = i;
		return idx;
	endfunction

	task automatic wait_for_ready();
		int n;
		n = 0;
		while (ready !== 1'b1 && n < READY_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (ready !== 1'b1)
		begin
			$display("ready never went high after reset, gave up at %0t", $time);
			missing++;
		end
	endtask

	// Called on a falling edge, returns four cycles later
	task automatic send_sample(input heap_pkg::data_t value);
		int slot;
		heap_pkg::data_t expected;
		slot = lowest_slot();
		expected = (value < model[slot]) ? value : model[slot];
		if (rec_en && !(value < model[slot]))
			model[slot] = value;
		data_in = value;
		fs = 1'b1;
		samples_sent++;
		@(negedge clk);
		@(negedge clk);
		fs = 1'b0;
		// Output register was loaded on the last rising edge
		if (out_valid !== 1'b1)
		begin
			$display("No output pulse for sample %0d (value %0h) at %0t",
				samples_sent, value, $time);
			missing++;
		end
		else
		begin
			a_data_out: assert (data_out === expected)
			else
			begin
				$display("Mismatch at %0t: sample %0d expected %0h, got %0h",
					$time, samples_sent, expected, data_out);
				mismatches++;
			end
		end
		@(negedge clk);
		@(negedge clk);
	endtask

	initial
	begin : watchdog
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		int i;
		int afail;
		void'($urandom(32'hacb9540f));
		restart = 1'b0;
		fs = 1'b0;
		rec_en = 1'b0;
		data_in = '0;
		mismatches = 0;
		missing = 0;
		samples_sent = 0;
		clear_model();
		wait_for_ready();

		// Recorded samples at minimum spacing keep several waves in flight
		rec_en = 1'b1;
		repeat (100) send_sample(heap_pkg::data_t'($urandom));

		// Heap must stay unchanged while recording is off
		rec_en = 1'b0;
		repeat (20) send_sample(heap_pkg::data_t'($urandom));
		rec_en = 1'b1;
		repeat (30) send_sample(heap_pkg::data_t'($urandom));

		// Descending run pushes stored values out in order
		for (i = 0; i < 40; i++)
			send_sample(heap_pkg::data_t'(60000 - i * 1000));

		restart = 1'b1;
		@(negedge clk);
		restart = 1'b0;
		while (rst)
			@(negedge clk);

		// Edge during the clear sweep gets no output
		fs = 1'b1;
		@(negedge clk);
		@(negedge clk);
		fs = 1'b0;
		clear_model();
		wait_for_ready();

		// First 63 recorded samples only displace zeros
		repeat (73) send_sample(heap_pkg::data_t'($urandom));

		repeat (10) @(negedge clk);
		afail = u_streaming_heap.u_asserts.fail_count;
		$display("Samples: %0d, mismatches: %0d, missing outputs: %0d, assertion failures: %0d",
			samples_sent, mismatches, missing, afail);
		if (mismatches + missing + afail == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	input  logic restart,
	output logic clk,
	output logic rst
);

	initial clk = 1'b0;

	// 8 ns period
	always #4 clk = ~clk;

	// Reset is held for 8 clock cycles at start and after every restart request
	initial
	begin
		rst = 1'b1;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		forever
		begin
			@(posedge restart);
			rst = 1'b1;
			repeat (8) @(negedge clk);
			rst = 1'b0;
		end
	end

endmodule
